/* build.f */
logic/gat_pkg.sv
logic/wh_row_memory.sv
logic/dmvm_ctrl.sv
logic/dot_product_tree.sv
logic/coef_bank.sv
logic/gat_coef_top.sv
verif/clk_gen.sv
verif/gat_coef_assertions.sv
verif/gat_coef_tb.sv

/* verif/gat_coef_tb.sv */
`default_nettype none

module gat_coef_tb #(
  parameter int DATA_W    = gat_pkg::DEF_DATA_W,
  parameter int HALF_A    = gat_pkg::DEF_HALF_A,
  parameter int MAX_NODES = gat_pkg::DEF_MAX_NODES,
  parameter int ROW_AW    = gat_pkg::DEF_ROW_AW
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CNT_W   = $clog2(MAX_NODES + 1);
  localparam int ROW_W   = DATA_W * HALF_A + CNT_W + 1;
  localparam int DEPTH   = 2**ROW_AW;
  localparam int MAXV    = 2**DATA_W - 1;
  localparam int ROW_CYC = 3 + $clog2(HALF_A);
  localparam int TIMEOUT = 1000;

  logic              clk;
  logic              rst_n;
  logic              wh_we;
  logic [ROW_AW-1:0] wh_waddr;
  logic [ROW_W-1:0]  wh_wdata;
  logic              vec_load;
  logic [DATA_W-1:0] vec_drv [2*HALF_A];
  logic              start;
  logic [ROW_AW-1:0] base_addr;
  logic [DATA_W-1:0] coef [MAX_NODES];
  logic [CNT_W-1:0]  num_nodes;
  logic              busy;
  logic              done;

  // host-side copy of what was written and loaded
  logic [ROW_W-1:0]  model_rows [DEPTH];
  logic [DATA_W-1:0] model_vec  [2*HALF_A];
  int                exp_base = 0;
  integer            seed     = 66;

  clk_gen #(.PERIOD_NS(10), .RST_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

  gat_coef_top #(
    .DATA_W    (DATA_W),
    .HALF_A    (HALF_A),
    .MAX_NODES (MAX_NODES),
    .ROW_AW    (ROW_AW)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_we_i     (wh_we),
    .wh_waddr_i  (wh_waddr),
    .wh_wdata_i  (wh_wdata),
    .vec_load_i  (vec_load),
    .vec_i       (vec_drv),
    .start_i     (start),
    .base_addr_i (base_addr),
    .coef_o      (coef),
    .num_nodes_o (num_nodes),
    .busy_o      (busy),
    .done_o      (done)
  );

  bind dmvm_ctrl gat_coef_assertions u_ctrl_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .state_i    (state_q),
    .busy_i     (busy_o),
    .done_i     (done_o),
    .store_en_i (store_en_o),
    .mul_en_i   (mul_en_o)
  );

  // lane products with byte fold, then pairwise tree with bit fold
  function automatic logic [DATA_W-1:0] row_score(input logic [ROW_W-1:0] row,
                                                  input logic [DATA_W-1:0] vec [2*HALF_A]);
    logic [DATA_W-1:0]   lanes [HALF_A];
    logic [DATA_W-1:0]   a;
    logic [2*DATA_W-1:0] prod;
    logic [DATA_W:0]     sum;
    int                  width;
    for (int i = 0; i < HALF_A; i++) begin
      a     = row[0] ? vec[i] : vec[i + HALF_A];
      prod  = row[ROW_W-1 - i*DATA_W -: DATA_W] * a;
      lanes[i] = (prod > MAXV) ? DATA_W'(prod >> DATA_W) : DATA_W'(prod);
    end
    width = HALF_A;
    while (width > 1) begin
      for (int k = 0; k < width / 2; k++) begin
        sum = {1'b0, lanes[2*k]} + {1'b0, lanes[2*k+1]};
        lanes[k] = (sum > MAXV) ? DATA_W'(sum >> 1) : DATA_W'(sum);
      end
      width = width / 2;
    end
    return lanes[0];
  endfunction

  // self score plus node score, saturated, zero past the node count
  function automatic logic [DATA_W-1:0] ref_coef(input logic [ROW_W-1:0] rows [DEPTH],
                                                 input logic [DATA_W-1:0] vec [2*HALF_A],
                                                 input int base, input int idx);
    logic [CNT_W-1:0] count;
    logic [DATA_W:0]  sum;
    count = rows[base][CNT_W:1];
    if (idx >= count) begin
      return '0;
    end
    sum = {1'b0, row_score(rows[base], vec)} + {1'b0, row_score(rows[(base + idx) % DEPTH], vec)};
    return (sum > MAXV) ? DATA_W'(MAXV) : DATA_W'(sum);
  endfunction

  function automatic logic [DATA_W-1:0] rand_val(input int lo, input int hi);
    return DATA_W'(lo + ($unsigned($random(seed)) % (hi - lo + 1)));
  endfunction

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_coef(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch at %0t ns: %s is %0d cycles, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // results compared on the falling edge of the done pulse
  always @(negedge clk) begin
    if (rst_n && done) begin
      check_count("num_nodes_o", num_nodes, model_rows[exp_base][CNT_W:1]);
      for (int i = 0; i < MAX_NODES; i++) begin
        check_coef($sformatf("coef_o[%0d]", i), coef[i],
                   ref_coef(model_rows, model_vec, exp_base, i));
      end
    end
  end

  // bound controller checks
  always @(negedge clk) begin
    if (dut_i.u_ctrl.u_ctrl_checks.fail_cnt != 0) begin
      $display("Controller assertion failed before %0t ns", $time);
      stop_on_error();
    end
  end

  task automatic wait_reset();
    int cyc;
    cyc = 0;
    while (!rst_n && cyc < 20) begin
      @(negedge clk);
      cyc++;
    end
    if (!rst_n) begin
      $display("Timeout at %0t ns: reset was never released", $time);
      stop_on_error();
    end
  endtask

  task automatic wait_done(input int expect_cyc);
    int cyc;
    bit seen;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      seen = done;
    end
    if (!seen) begin
      $display("Timeout at %0t ns: done_o never came after start", $time);
      stop_on_error();
    end
    if (expect_cyc >= 0) begin
      check_latency("done_o latency", cyc, expect_cyc);
    end
  endtask

  task automatic write_row(input int addr, input logic [ROW_W-1:0] row);
    @(negedge clk);
    wh_we    = 1'b1;
    wh_waddr = ROW_AW'(addr);
    wh_wdata = row;
    model_rows[addr] = row;
    @(negedge clk);
    wh_we = 1'b0;
  endtask

  // first row is the source node and carries the count
  task automatic fill_graph(input int base, input int count, input int lo, input int hi);
    logic [ROW_W-1:0] row;
    for (int r = 0; r < count; r++) begin
      row    = '0;
      row[0] = (r == 0);
      if (r == 0) begin
        row[CNT_W:1] = CNT_W'(count);
      end
      for (int i = 0; i < HALF_A; i++) begin
        row[ROW_W-1 - i*DATA_W -: DATA_W] = rand_val(lo, hi);
      end
      write_row((base + r) % DEPTH, row);
    end
  endtask

  task automatic load_vector(input int lo, input int hi);
    @(negedge clk);
    for (int i = 0; i < 2*HALF_A; i++) begin
      vec_drv[i]   = rand_val(lo, hi);
      model_vec[i] = vec_drv[i];
    end
    vec_load = 1'b1;
    @(negedge clk);
    vec_load = 1'b0;
  endtask

  task automatic start_run(input int base);
    @(negedge clk);
    start     = 1'b1;
    base_addr = ROW_AW'(base);
    exp_base  = base;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_graph(input int base, input int count);
    start_run(base);
    wait_done(count * ROW_CYC + 1);
  endtask

  initial begin
    wh_we     = 1'b0;
    wh_waddr  = '0;
    wh_wdata  = '0;
    vec_load  = 1'b0;
    start     = 1'b0;
    base_addr = '0;
    for (int i = 0; i < 2*HALF_A; i++) begin
      vec_drv[i] = '0;
    end
    wait_reset();

    // idle outputs before any start
    @(negedge clk);
    check_flag("busy_o", busy, 1'b0);
    check_flag("done_o", done, 1'b0);
    check_count("num_nodes_o", num_nodes, '0);
    for (int i = 0; i < MAX_NODES; i++) begin
      check_coef($sformatf("coef_o[%0d]", i), coef[i], '0);
    end

    // full sub-graph, small values
    fill_graph(0, MAX_NODES, 0, 3);
    load_vector(0, 3);
    run_graph(0, MAX_NODES);

    // large values force both folds and the saturating combine
    fill_graph(8, MAX_NODES, 128, 255);
    load_vector(128, 255);
    run_graph(8, MAX_NODES);

    // short sub-graph right after a full one
    fill_graph(16, 3, 0, 255);
    load_vector(0, 255);
    run_graph(16, 3);

    // second start and a vector load while busy are dropped
    fill_graph(24, 6, 0, 255);
    load_vector(0, 127);
    start_run(24);
    @(negedge clk);
    start     = 1'b1;
    base_addr = '0;
    vec_load  = 1'b1;
    for (int i = 0; i < 2*HALF_A; i++) begin
      vec_drv[i] = rand_val(128, 255);
    end
    @(negedge clk);
    start    = 1'b0;
    vec_load = 1'b0;
    wait_done(-1);
    for (int c = 0; c < 4 * ROW_CYC; c++) begin
      @(negedge clk);
      check_flag("done_o", done, 1'b0);
      check_flag("busy_o", busy, 1'b0);
    end

    // back to back, second one wraps around the row memory
    fill_graph(2, 5, 0, 255);
    fill_graph(30, 4, 64, 255);
    load_vector(0, 255);
    run_graph(2, 5);
    run_graph(30, 4);

    repeat (2) @(negedge clk);
    if (dut_i.u_ctrl.u_ctrl_checks.fail_cnt == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Controller assertion failed before %0t ns", $time);
      stop_on_error();
    end
  end

endmodule

`default_nettype wire

/* verif/gat_coef_assertions.sv */
`default_nettype none

module gat_coef_assertions (
  input wire logic                 clk,
  input wire logic                 rst_n,
  input wire gat_pkg::ctrl_state_e state_i,
  input wire logic                 busy_i,
  input wire logic                 done_i,
  input wire logic                 store_en_i,
  input wire logic                 mul_en_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  int fail_cnt = 0;

  // done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i)
    else begin
      $error("done_o stayed high for more than one cycle");
      fail_cnt++;
    end

  // ACT hands back to IDLE, busy drops as done rises
  act_ends_run: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ACT) |=> ((state_i == IDLE) && !busy_i && done_i))
    else begin
      $error("run did not end in IDLE with busy_o low and done_o high after ACT");
      fail_cnt++;
    end

  // one row in flight, no write-back with or right after the capture
  store_after_mul: assert property (@(posedge clk) disable iff (!rst_n)
    mul_en_i |-> !store_en_i ##1 !store_en_i)
    else begin
      $error("store_en high together with or right after mul_en");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset released on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* logic/gat_coef_top.sv */
`default_nettype none

module gat_coef_top #(
  parameter int DATA_W    = gat_pkg::DEF_DATA_W,
  parameter int HALF_A    = gat_pkg::DEF_HALF_A,
  parameter int MAX_NODES = gat_pkg::DEF_MAX_NODES,
  parameter int ROW_AW    = gat_pkg::DEF_ROW_AW,
  localparam int CNT_W    = $clog2(MAX_NODES + 1),
  localparam int IDX_W    = $clog2(MAX_NODES),
  localparam int WGT_W    = DATA_W * HALF_A,
  localparam int ROW_W    = WGT_W + CNT_W + 1
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              wh_we_i,
  input  wire logic [ROW_AW-1:0] wh_waddr_i,
  input  wire logic [ROW_W-1:0]  wh_wdata_i,
  input  wire logic              vec_load_i,
  input  wire logic [DATA_W-1:0] vec_i [2*HALF_A],
  input  wire logic              start_i,
  input  wire logic [ROW_AW-1:0] base_addr_i,
  output logic      [DATA_W-1:0] coef_o [MAX_NODES],
  output logic      [CNT_W-1:0]  num_nodes_o,
  output logic                   busy_o,
  output logic                   done_o
);

  logic              rd_en;
  logic [ROW_AW-1:0] rd_addr;
  logic [ROW_W-1:0]  row_data;
  logic [WGT_W:0]    tree_row;
  logic              mul_en;
  logic              red_en;
  logic              store_en;
  logic              clear_en;
  logic              act_en;
  logic [IDX_W-1:0]  node_idx;
  logic [DATA_W-1:0] score;
  logic              vec_load_ok;

  // vector held steady while a run is in flight
  assign vec_load_ok = vec_load_i && !busy_o;
  // tree sees weights and source flag, count field stripped
  assign tree_row = {row_data[ROW_W-1 -: WGT_W], row_data[0]};

  wh_row_memory #(
    .ROW_W  (ROW_W),
    .ROW_AW (ROW_AW)
  ) u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (wh_we_i),
    .wr_addr_i (wh_waddr_i),
    .wr_data_i (wh_wdata_i),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (row_data)
  );

  dmvm_ctrl #(
    .DATA_W    (DATA_W),
    .HALF_A    (HALF_A),
    .MAX_NODES (MAX_NODES),
    .ROW_AW    (ROW_AW)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .base_addr_i  (base_addr_i),
    .row_data_i   (row_data),
    .rd_en_o      (rd_en),
    .rd_addr_o    (rd_addr),
    .mul_en_o     (mul_en),
    .red_en_o     (red_en),
    .store_en_o   (store_en),
    .clear_en_o   (clear_en),
    .act_en_o     (act_en),
    .node_idx_o   (node_idx),
    .node_count_o (num_nodes_o),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  dot_product_tree #(
    .DATA_W (DATA_W),
    .HALF_A (HALF_A)
  ) u_tree (
    .clk        (clk),
    .rst_n      (rst_n),
    .vec_load_i (vec_load_ok),
    .vec_i      (vec_i),
    .row_data_i (tree_row),
    .mul_en_i   (mul_en),
    .red_en_i   (red_en),
    .score_o    (score)
  );

  coef_bank #(
    .DATA_W    (DATA_W),
    .MAX_NODES (MAX_NODES)
  ) u_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_en_i   (clear_en),
    .store_en_i   (store_en),
    .act_en_i     (act_en),
    .node_idx_i   (node_idx),
    .node_count_i (num_nodes_o),
    .score_i      (score),
    .coef_o       (coef_o)
  );

endmodule

`default_nettype wire

/* logic/coef_bank.sv */
`default_nettype none

module coef_bank #(
  parameter int DATA_W    = gat_pkg::DEF_DATA_W,
  parameter int MAX_NODES = gat_pkg::DEF_MAX_NODES,
  localparam int CNT_W    = $clog2(MAX_NODES + 1),
  localparam int IDX_W    = $clog2(MAX_NODES)
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              clear_en_i,
  input  wire logic              store_en_i,
  input  wire logic              act_en_i,
  input  wire logic [IDX_W-1:0]  node_idx_i,
  input  wire logic [CNT_W-1:0]  node_count_i,
  input  wire logic [DATA_W-1:0] score_i,
  output logic      [DATA_W-1:0] coef_o [MAX_NODES]
);

  logic [DATA_W-1:0] score_q  [MAX_NODES];
  logic [DATA_W-1:0] coef_q   [MAX_NODES];
  logic [DATA_W-1:0] coef_nxt [MAX_NODES];

  // per-node scores, cleared at the start of each sub-graph
  always_ff @(posedge clk) begin
    if (clear_en_i) begin
      for (int i = 0; i < MAX_NODES; i++) begin
        score_q[i] <= '0;
      end
    end else if (store_en_i) begin
      score_q[node_idx_i] <= score_i;
    end
  end

  // self score plus node score, saturated, masked past the count
  for (genvar i = 0; i < MAX_NODES; i++) begin : g_coef
    logic [DATA_W:0] pair_sum;

    assign pair_sum = score_q[0] + score_q[i];
    assign coef_nxt[i] = (i >= node_count_i) ? '0
                       : pair_sum[DATA_W]    ? {DATA_W{1'b1}}
                       : pair_sum[DATA_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < MAX_NODES; i++) begin
        coef_q[i] <= '0;
      end
    end else if (act_en_i) begin
      coef_q <= coef_nxt;
    end
  end

  assign coef_o = coef_q;

endmodule

`default_nettype wire

/* logic/dot_product_tree.sv */
`default_nettype none

module dot_product_tree #(
  parameter int DATA_W = gat_pkg::DEF_DATA_W,
  parameter int HALF_A = gat_pkg::DEF_HALF_A,
  localparam int WGT_W = DATA_W * HALF_A
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              vec_load_i,
  input  wire logic [DATA_W-1:0] vec_i [2*HALF_A],
  input  wire logic [WGT_W:0]    row_data_i,
  input  wire logic              mul_en_i,
  input  wire logic              red_en_i,
  output logic      [DATA_W-1:0] score_o
);

  logic [DATA_W-1:0] vec_q     [2*HALF_A];
  logic [DATA_W-1:0] lane_q    [HALF_A];
  logic [DATA_W-1:0] prod_fold [HALF_A];
  logic [DATA_W-1:0] sum_fold  [HALF_A/2];
  logic              src_flag;

  assign src_flag = row_data_i[0];

  // attention vector, first half for the source node
  always_ff @(posedge clk) begin
    if (vec_load_i) begin
      vec_q <= vec_i;
    end
  end

  // lane products, lane 0 weight sits in the top byte
  for (genvar i = 0; i < HALF_A; i++) begin : g_lane
    logic [DATA_W-1:0]   weight;
    logic [DATA_W-1:0]   a_sel;
    logic [2*DATA_W-1:0] prod;

    assign weight = row_data_i[WGT_W - i*DATA_W -: DATA_W];
    assign a_sel  = src_flag ? vec_q[i] : vec_q[i + HALF_A];
    assign prod   = weight * a_sel;
    // overflow keeps the upper byte
    assign prod_fold[i] = (prod[2*DATA_W-1:DATA_W] != '0) ? prod[2*DATA_W-1:DATA_W]
                                                          : prod[DATA_W-1:0];
  end

  // one tree level, pair k lands in lane k
  for (genvar k = 0; k < HALF_A/2; k++) begin : g_pair
    logic [DATA_W:0] sum;

    assign sum = lane_q[2*k] + lane_q[2*k+1];
    // carry out drops the lsb instead
    assign sum_fold[k] = sum[DATA_W] ? sum[DATA_W:1] : sum[DATA_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < HALF_A; i++) begin
        lane_q[i] <= '0;
      end
    end else if (mul_en_i) begin
      lane_q <= prod_fold;
    end else if (red_en_i) begin
      for (int k = 0; k < HALF_A/2; k++) begin
        lane_q[k] <= sum_fold[k];
      end
    end
  end

  assign score_o = lane_q[0];

endmodule

`default_nettype wire

/* logic/dmvm_ctrl.sv */
`default_nettype none

module dmvm_ctrl #(
  parameter int DATA_W    = gat_pkg::DEF_DATA_W,
  parameter int HALF_A    = gat_pkg::DEF_HALF_A,
  parameter int MAX_NODES = gat_pkg::DEF_MAX_NODES,
  parameter int ROW_AW    = gat_pkg::DEF_ROW_AW,
  localparam int CNT_W    = $clog2(MAX_NODES + 1),
  localparam int IDX_W    = $clog2(MAX_NODES),
  localparam int ROW_W    = DATA_W * HALF_A + CNT_W + 1
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              start_i,
  input  wire logic [ROW_AW-1:0] base_addr_i,
  input  wire logic [ROW_W-1:0]  row_data_i,
  output logic                   rd_en_o,
  output logic      [ROW_AW-1:0] rd_addr_o,
  output logic                   mul_en_o,
  output logic                   red_en_o,
  output logic                   store_en_o,
  output logic                   clear_en_o,
  output logic                   act_en_o,
  output logic      [IDX_W-1:0]  node_idx_o,
  output logic      [CNT_W-1:0]  node_count_o,
  output logic                   busy_o,
  output logic                   done_o
);

  import gat_pkg::*;

  // tree depth in REDUCE cycles
  localparam int LVLS  = $clog2(HALF_A);
  localparam int LVL_W = $clog2(LVLS + 1);

  ctrl_state_e       state_q;
  logic [ROW_AW-1:0] base_q;
  logic [IDX_W-1:0]  row_cnt_q;
  logic [LVL_W-1:0]  lvl_cnt_q;
  logic [CNT_W-1:0]  run_cnt_q;
  logic [CNT_W-1:0]  out_cnt_q;
  logic              done_q;
  logic              last_row;

  // stop at node count, or at the last slot if the count field is too big
  assign last_row = ((CNT_W'(row_cnt_q) + 1'b1) >= run_cnt_q) ||
                    (row_cnt_q == IDX_W'(MAX_NODES - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      base_q    <= '0;
      row_cnt_q <= '0;
      lvl_cnt_q <= '0;
      run_cnt_q <= '0;
      out_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            base_q    <= base_addr_i;
            row_cnt_q <= '0;
            lvl_cnt_q <= '0;
            state_q   <= FETCH;
          end
        end
        FETCH: state_q <= MUL;
        MUL: begin
          // source row carries the node count
          if (row_cnt_q == '0) begin
            run_cnt_q <= row_data_i[CNT_W:1];
          end
          state_q <= REDUCE;
        end
        REDUCE: begin
          if (lvl_cnt_q == LVL_W'(LVLS - 1)) begin
            lvl_cnt_q <= '0;
            state_q   <= STORE;
          end else begin
            lvl_cnt_q <= lvl_cnt_q + 1'b1;
          end
        end
        STORE: begin
          if (last_row) begin
            state_q <= ACT;
          end else begin
            row_cnt_q <= row_cnt_q + 1'b1;
            state_q   <= FETCH;
          end
        end
        ACT: begin
          out_cnt_q <= run_cnt_q;
          done_q    <= 1'b1;
          state_q   <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign rd_en_o    = (state_q == FETCH);
  assign rd_addr_o  = base_q + ROW_AW'(row_cnt_q);
  assign mul_en_o   = (state_q == MUL);
  assign red_en_o   = (state_q == REDUCE);
  assign store_en_o = (state_q == STORE);
  // old scores wiped while the first row is fetched
  assign clear_en_o = (state_q == FETCH) && (row_cnt_q == '0);
  assign act_en_o   = (state_q == ACT);
  assign node_idx_o = row_cnt_q;
  // published count only moves when the new coefficients are formed
  assign node_count_o = (state_q == ACT) ? run_cnt_q : out_cnt_q;
  assign busy_o     = (state_q != IDLE);
  assign done_o     = done_q;

endmodule

`default_nettype wire

/* logic/wh_row_memory.sv */
`default_nettype none

module wh_row_memory #(
  parameter int ROW_W  = 45,
  parameter int ROW_AW = gat_pkg::DEF_ROW_AW
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              wr_en_i,
  input  wire logic [ROW_AW-1:0] wr_addr_i,
  input  wire logic [ROW_W-1:0]  wr_data_i,
  input  wire logic              rd_en_i,
  input  wire logic [ROW_AW-1:0] rd_addr_i,
  output logic      [ROW_W-1:0]  rd_data_o
);

  logic [ROW_W-1:0] mem_q [2**ROW_AW];
  logic [ROW_W-1:0] rd_data_q;

  // host write port
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data_q <= '0;
    end else if (rd_en_i) begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

/* logic/gat_pkg.sv */
`default_nettype none

package gat_pkg;

  // element width of vector entries, weights, scores and coefficients
  parameter int DEF_DATA_W = 8;

  // lanes per row, half of the attention vector, power of two
  parameter int DEF_HALF_A = 8;

  // nodes per sub-graph, also the number of coefficients
  parameter int DEF_MAX_NODES = 8;

  // row memory address width
  parameter int DEF_ROW_AW = 5;

  // controller sequence, one row walks FETCH to STORE
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    MUL,
    REDUCE,
    STORE,
    ACT
  } ctrl_state_e;

endpackage

`default_nettype wire
